// ==== axi_fifo_bridge.f ====
+incdir+include
logic/axi_proto_pkg.sv
logic/mem_fifo_pkg.sv
logic/two_entry_fifo.sv
logic/axi_burst_pump.sv
logic/beat_counter.sv
logic/fifo_issue_fsm.sv
logic/axi_fifo_bridge.sv
verification/tb_clock_gen.sv
verification/mem_responder.sv
verification/axi_fifo_bridge_tb.sv

// ==== include/axi_fifo_bridge_config.svh ====
`ifndef AXI_FIFO_BRIDGE_CONFIG_SVH
`define AXI_FIFO_BRIDGE_CONFIG_SVH

// one memory word per transfer
`define BRIDGE_DATA_W 64

// byte address on both sides
`define BRIDGE_ADDR_W 32

// AXI transaction ID
`define BRIDGE_ID_W 4

// one strobe bit per data byte
`define BRIDGE_MASK_W (`BRIDGE_DATA_W / 8)

// width of axlen and of the beat counters
`define BRIDGE_BEAT_CNT_W 8

`endif

// ==== logic/axi_burst_pump.sv ====
`default_nettype none

`include "axi_fifo_bridge_config.svh"

module axi_burst_pump (
  input  logic                      clk_i
  , input  logic                      reset_i
  , input  logic                      v_i
  , output logic                      ready_o
  , input  logic [`BRIDGE_ADDR_W-1:0] addr_i
  , input  axi_proto_pkg::axi_burst_e burst_i
  , input  axi_proto_pkg::axi_len_t   len_i
  , input  axi_proto_pkg::axi_size_t  size_i
  , input  logic                      send_i
  , output logic                      v_o
  , output logic [`BRIDGE_ADDR_W-1:0] addr_o
  , output axi_proto_pkg::axi_size_t  size_o
  , output axi_proto_pkg::axi_len_t   len_o
  , output logic                      first_o
  , output logic                      last_o
);

  import axi_proto_pkg::*;

  logic                      busy_r;
  logic [`BRIDGE_ADDR_W-1:0] addr_r;
  logic [`BRIDGE_ADDR_W-1:0] beat_bytes;
  axi_burst_e                burst_r;
  axi_len_t                  len_r;
  axi_len_t                  remain_r;
  axi_size_t                 size_r;
  logic                      accept;

  assign accept  = v_i & ~busy_r;
  assign ready_o = ~busy_r;

  assign v_o     = busy_r;
  assign addr_o  = addr_r;
  assign size_o  = size_r;
  assign len_o   = len_r;
  // remain_r counts down from len to zero over the burst
  assign first_o = (remain_r == len_r);
  assign last_o  = (remain_r == '0);

  assign beat_bytes = {{(`BRIDGE_ADDR_W-1){1'b0}}, 1'b1} << size_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
    end else if (accept) begin
      busy_r <= 1'b1;
    end else if (send_i & last_o) begin
      busy_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_r   <= addr_i;
      burst_r  <= burst_i;
      len_r    <= len_i;
      size_r   <= size_i;
      remain_r <= len_i;
    end else if (send_i & ~last_o) begin
      remain_r <= remain_r - 1'b1;
      // FIXED bursts keep hitting the same address
      if (burst_r == e_burst_incr) begin
        addr_r <= addr_r + beat_bytes;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/axi_fifo_bridge.sv ====
`default_nettype none

`include "axi_fifo_bridge_config.svh"

module axi_fifo_bridge (
  input  logic                        clk_i
  , input  logic                        reset_i
  // AW
  , input  logic [`BRIDGE_ID_W-1:0]     s_axi_awid_i
  , input  logic [`BRIDGE_ADDR_W-1:0]   s_axi_awaddr_i
  , input  axi_proto_pkg::axi_len_t     s_axi_awlen_i
  , input  axi_proto_pkg::axi_size_t    s_axi_awsize_i
  , input  axi_proto_pkg::axi_burst_e   s_axi_awburst_i
  , input  logic                        s_axi_awvalid_i
  , output logic                        s_axi_awready_o
  // W
  , input  logic [`BRIDGE_DATA_W-1:0]   s_axi_wdata_i
  , input  logic [`BRIDGE_MASK_W-1:0]   s_axi_wstrb_i
  , input  logic                        s_axi_wlast_i
  , input  logic                        s_axi_wvalid_i
  , output logic                        s_axi_wready_o
  // B
  , output logic [`BRIDGE_ID_W-1:0]     s_axi_bid_o
  , output axi_proto_pkg::axi_resp_e    s_axi_bresp_o
  , output logic                        s_axi_bvalid_o
  , input  logic                        s_axi_bready_i
  // AR
  , input  logic [`BRIDGE_ID_W-1:0]     s_axi_arid_i
  , input  logic [`BRIDGE_ADDR_W-1:0]   s_axi_araddr_i
  , input  axi_proto_pkg::axi_len_t     s_axi_arlen_i
  , input  axi_proto_pkg::axi_size_t    s_axi_arsize_i
  , input  axi_proto_pkg::axi_burst_e   s_axi_arburst_i
  , input  logic                        s_axi_arvalid_i
  , output logic                        s_axi_arready_o
  // R
  , output logic [`BRIDGE_ID_W-1:0]     s_axi_rid_o
  , output logic [`BRIDGE_DATA_W-1:0]   s_axi_rdata_o
  , output axi_proto_pkg::axi_resp_e    s_axi_rresp_o
  , output logic                        s_axi_rlast_o
  , output logic                        s_axi_rvalid_o
  , input  logic                        s_axi_rready_i
  // memory requests
  , output logic                        mem_v_o
  , output mem_fifo_pkg::mem_cmd_e      mem_cmd_o
  , output logic [`BRIDGE_ADDR_W-1:0]   mem_addr_o
  , output axi_proto_pkg::axi_size_t    mem_size_o
  , output logic [`BRIDGE_MASK_W-1:0]   mem_wmask_o
  , output logic [`BRIDGE_DATA_W-1:0]   mem_data_o
  , input  logic                        mem_ready_i
  // memory responses
  , input  logic                        mem_rsp_v_i
  , input  mem_fifo_pkg::mem_cmd_e      mem_rsp_cmd_i
  , input  logic [`BRIDGE_DATA_W-1:0]   mem_rsp_data_i
  , output logic                        mem_rsp_ready_o
);

  import axi_proto_pkg::*;
  import mem_fifo_pkg::*;

  logic                      awpump_ready, awpump_v, awpump_first, awpump_last, aw_send;
  logic [`BRIDGE_ADDR_W-1:0] awpump_addr;
  axi_size_t                 awpump_size;
  axi_len_t                  awpump_len;
  logic                      awid_ready, awid_v;
  logic [`BRIDGE_ID_W-1:0]   awid;

  logic                      arpump_ready, arpump_v, arpump_first, arpump_last, ar_send;
  logic [`BRIDGE_ADDR_W-1:0] arpump_addr;
  axi_size_t                 arpump_size;
  axi_len_t                  arpump_len;
  logic                      arid_ready, arid_v;
  logic [`BRIDGE_ID_W-1:0]   arid;

  wbeat_t                    wbeat;
  logic                      wbeat_v;
  mem_rsp_t                  rsp;
  logic                      rsp_v, rsp_yumi, rsp_is_write;
  logic                      cnt_load, cnt_zero;
  axi_len_t                  cnt_val;
  logic                      bsend, rsend, txn_done;

  // a command is taken only when both its pump and its ID slot have room
  assign s_axi_awready_o = awpump_ready & awid_ready;
  assign s_axi_arready_o = arpump_ready & arid_ready;

  axi_burst_pump aw_pump (
    .clk_i(clk_i), .reset_i(reset_i)
    , .v_i(s_axi_awvalid_i & awid_ready), .ready_o(awpump_ready)
    , .addr_i(s_axi_awaddr_i), .burst_i(s_axi_awburst_i)
    , .len_i(s_axi_awlen_i), .size_i(s_axi_awsize_i)
    , .send_i(aw_send), .v_o(awpump_v), .addr_o(awpump_addr)
    , .size_o(awpump_size), .len_o(awpump_len)
    , .first_o(awpump_first), .last_o(awpump_last)
  );

  axi_burst_pump ar_pump (
    .clk_i(clk_i), .reset_i(reset_i)
    , .v_i(s_axi_arvalid_i & arid_ready), .ready_o(arpump_ready)
    , .addr_i(s_axi_araddr_i), .burst_i(s_axi_arburst_i)
    , .len_i(s_axi_arlen_i), .size_i(s_axi_arsize_i)
    , .send_i(ar_send), .v_o(arpump_v), .addr_o(arpump_addr)
    , .size_o(arpump_size), .len_o(arpump_len)
    , .first_o(arpump_first), .last_o(arpump_last)
  );

  // IDs leave on the final B or R of their transaction
  two_entry_fifo #(.payload_t(logic [`BRIDGE_ID_W-1:0])) awid_fifo (
    .clk_i(clk_i), .reset_i(reset_i)
    , .data_i(s_axi_awid_i), .v_i(s_axi_awvalid_i & awpump_ready), .ready_o(awid_ready)
    , .data_o(awid), .v_o(awid_v), .yumi_i(bsend)
  );

  two_entry_fifo #(.payload_t(logic [`BRIDGE_ID_W-1:0])) arid_fifo (
    .clk_i(clk_i), .reset_i(reset_i)
    , .data_i(s_axi_arid_i), .v_i(s_axi_arvalid_i & arpump_ready), .ready_o(arid_ready)
    , .data_o(arid), .v_o(arid_v), .yumi_i(rsend & cnt_zero)
  );

  // beat boundaries come from awlen in the pump, so wlast is not looked at
  two_entry_fifo #(.payload_t(wbeat_t)) w_fifo (
    .clk_i(clk_i), .reset_i(reset_i)
    , .data_i('{mask: s_axi_wstrb_i, data: s_axi_wdata_i})
    , .v_i(s_axi_wvalid_i), .ready_o(s_axi_wready_o)
    , .data_o(wbeat), .v_o(wbeat_v), .yumi_i(aw_send)
  );

  assign mem_wmask_o = wbeat.mask;
  assign mem_data_o  = wbeat.data;

  two_entry_fifo #(.payload_t(mem_rsp_t)) rsp_fifo (
    .clk_i(clk_i), .reset_i(reset_i)
    , .data_i('{cmd: mem_rsp_cmd_i, data: mem_rsp_data_i})
    , .v_i(mem_rsp_v_i), .ready_o(mem_rsp_ready_o)
    , .data_o(rsp), .v_o(rsp_v), .yumi_i(rsp_yumi)
  );

  fifo_issue_fsm issue_fsm (
    .clk_i(clk_i), .reset_i(reset_i)
    , .ar_v_i(arpump_v), .ar_first_i(arpump_first), .ar_last_i(arpump_last)
    , .ar_addr_i(arpump_addr), .ar_size_i(arpump_size), .ar_len_i(arpump_len)
    , .aw_v_i(awpump_v), .aw_first_i(awpump_first), .aw_last_i(awpump_last)
    , .aw_addr_i(awpump_addr), .aw_size_i(awpump_size), .aw_len_i(awpump_len)
    , .wbeat_v_i(wbeat_v), .mem_ready_i(mem_ready_i), .txn_done_i(txn_done)
    , .mem_v_o(mem_v_o), .mem_cmd_o(mem_cmd_o)
    , .mem_addr_o(mem_addr_o), .mem_size_o(mem_size_o)
    , .ar_send_o(ar_send), .aw_send_o(aw_send)
    , .cnt_load_o(cnt_load), .cnt_val_o(cnt_val)
  );

  beat_counter rsp_counter (
    .clk_i(clk_i), .reset_i(reset_i)
    , .load_i(cnt_load), .load_val_i(cnt_val)
    , .step_i(rsp_yumi & ~cnt_zero), .zero_o(cnt_zero)
  );

  assign rsp_is_write = (rsp.cmd == e_mem_write);

  // only the last write response turns into a B beat
  assign s_axi_bvalid_o = rsp_v & rsp_is_write & cnt_zero & awid_v;
  assign s_axi_bid_o    = awid;
  assign s_axi_bresp_o  = e_resp_okay;
  assign bsend          = s_axi_bvalid_o & s_axi_bready_i;

  // every read response is an R beat
  assign s_axi_rvalid_o = rsp_v & ~rsp_is_write & arid_v;
  assign s_axi_rid_o    = arid;
  assign s_axi_rdata_o  = rsp.data;
  assign s_axi_rresp_o  = e_resp_okay;
  assign s_axi_rlast_o  = cnt_zero;
  assign rsend          = s_axi_rvalid_o & s_axi_rready_i;

  // earlier write responses are dropped without waiting on bready
  assign rsp_yumi = rsend | bsend | (rsp_v & rsp_is_write & ~cnt_zero);
  assign txn_done = bsend | (rsend & cnt_zero);

endmodule

`default_nettype wire

// ==== logic/axi_proto_pkg.sv ====
`default_nettype none

`include "axi_fifo_bridge_config.svh"

package axi_proto_pkg;

  // burst kinds handled by the bridge, WRAP is not supported
  typedef enum logic [1:0] {
    e_burst_fixed = 2'b00,
    e_burst_incr  = 2'b01
  } axi_burst_e;

  // response code, the bridge always answers OKAY
  typedef enum logic [1:0] {
    e_resp_okay = 2'b00
  } axi_resp_e;

  // log2 of the bytes in one beat
  typedef logic [2:0] axi_size_t;

  // number of beats minus one
  typedef logic [`BRIDGE_BEAT_CNT_W-1:0] axi_len_t;

endpackage

`default_nettype wire

// ==== logic/beat_counter.sv ====
`default_nettype none

module beat_counter (
  input  logic                    clk_i
  , input  logic                    reset_i
  , input  logic                    load_i
  , input  axi_proto_pkg::axi_len_t load_val_i
  , input  logic                    step_i
  , output logic                    zero_o
);

  import axi_proto_pkg::*;

  axi_len_t count_r;

  // zero means the response in front is the final one of the transaction
  assign zero_o = (count_r == '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (load_i) begin
      count_r <= load_val_i;
    end else if (step_i & ~zero_o) begin
      count_r <= count_r - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fifo_issue_fsm.sv ====
`default_nettype none

`include "axi_fifo_bridge_config.svh"

module fifo_issue_fsm (
  input  logic                      clk_i
  , input  logic                      reset_i
  , input  logic                      ar_v_i
  , input  logic                      ar_first_i
  , input  logic                      ar_last_i
  , input  logic [`BRIDGE_ADDR_W-1:0] ar_addr_i
  , input  axi_proto_pkg::axi_size_t  ar_size_i
  , input  axi_proto_pkg::axi_len_t   ar_len_i
  , input  logic                      aw_v_i
  , input  logic                      aw_first_i
  , input  logic                      aw_last_i
  , input  logic [`BRIDGE_ADDR_W-1:0] aw_addr_i
  , input  axi_proto_pkg::axi_size_t  aw_size_i
  , input  axi_proto_pkg::axi_len_t   aw_len_i
  , input  logic                      wbeat_v_i
  , input  logic                      mem_ready_i
  , input  logic                      txn_done_i
  , output logic                      mem_v_o
  , output mem_fifo_pkg::mem_cmd_e    mem_cmd_o
  , output logic [`BRIDGE_ADDR_W-1:0] mem_addr_o
  , output axi_proto_pkg::axi_size_t  mem_size_o
  , output logic                      ar_send_o
  , output logic                      aw_send_o
  , output logic                      cnt_load_o
  , output axi_proto_pkg::axi_len_t   cnt_val_o
);

  import mem_fifo_pkg::*;

  typedef enum logic [1:0] {
    e_idle,
    e_write_burst,
    e_read_burst,
    e_wait
  } state_e;

  state_e state_r;
  state_e state_n;
  logic   pick_read;
  logic   write_ready;

  assign write_ready = aw_v_i & wbeat_v_i;

  // reads win in IDLE, a burst in progress keeps its direction
  always_comb begin
    case (state_r)
      e_idle:       pick_read = ar_v_i;
      e_read_burst: pick_read = 1'b1;
      default:      pick_read = 1'b0;
    endcase
  end

  assign mem_cmd_o  = pick_read ? e_mem_read : e_mem_write;
  assign mem_addr_o = pick_read ? ar_addr_i : aw_addr_i;
  assign mem_size_o = pick_read ? ar_size_i : aw_size_i;
  assign mem_v_o    = (state_r != e_wait) & (pick_read ? ar_v_i : write_ready);

  assign ar_send_o  = mem_v_o & mem_ready_i & pick_read;
  assign aw_send_o  = mem_v_o & mem_ready_i & ~pick_read;

  // counter takes the length of whichever pump sent its first beat
  assign cnt_load_o = (ar_send_o & ar_first_i) | (aw_send_o & aw_first_i);
  assign cnt_val_o  = pick_read ? ar_len_i : aw_len_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      // once a request is offered, stay on it until the burst is sent
      e_idle: begin
        if (ar_v_i) begin
          state_n = (ar_send_o & ar_last_i) ? e_wait : e_read_burst;
        end else if (write_ready) begin
          state_n = (aw_send_o & aw_last_i) ? e_wait : e_write_burst;
        end
      end
      e_write_burst: begin
        if (aw_send_o & aw_last_i) begin
          state_n = e_wait;
        end
      end
      e_read_burst: begin
        if (ar_send_o & ar_last_i) begin
          state_n = e_wait;
        end
      end
      e_wait: begin
        if (txn_done_i) begin
          state_n = e_idle;
        end
      end
      default: state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
    end else begin
      state_r <= state_n;
    end
  end

endmodule

`default_nettype wire

// ==== logic/mem_fifo_pkg.sv ====
`default_nettype none

`include "axi_fifo_bridge_config.svh"

package mem_fifo_pkg;

  typedef enum logic {
    e_mem_read  = 1'b0,
    e_mem_write = 1'b1
  } mem_cmd_e;

  // one response per request, write responses carry no useful data
  typedef struct packed {
    mem_cmd_e                  cmd;
    logic [`BRIDGE_DATA_W-1:0] data;
  } mem_rsp_t;

  // a W beat waiting for its request slot
  typedef struct packed {
    logic [`BRIDGE_MASK_W-1:0] mask;
    logic [`BRIDGE_DATA_W-1:0] data;
  } wbeat_t;

endpackage

`default_nettype wire

// ==== logic/two_entry_fifo.sv ====
`default_nettype none

module two_entry_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i
  , input  logic     reset_i
  , input  payload_t data_i
  , input  logic     v_i
  , output logic     ready_o
  , output payload_t data_o
  , output logic     v_o
  , input  logic     yumi_i
);

  payload_t mem_r [2];
  logic     wr_ptr_r;
  logic     rd_ptr_r;
  logic     full_r;
  logic     empty;
  logic     enq;

  // equal pointers mean either full or empty, full_r tells them apart
  assign empty   = (wr_ptr_r == rd_ptr_r) & ~full_r;
  assign ready_o = ~full_r;
  assign v_o     = ~empty;
  assign data_o  = mem_r[rd_ptr_r];
  assign enq     = v_i & ~full_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      full_r   <= 1'b0;
    end else begin
      if (enq) begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (yumi_i) begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      // fills when a push lands on the second slot
      if (enq & ~yumi_i) begin
        full_r <= (wr_ptr_r != rd_ptr_r);
      end else if (yumi_i & ~enq) begin
        full_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== verification/axi_fifo_bridge_tb.sv ====
`default_nettype none

`include "axi_fifo_bridge_config.svh"

module axi_fifo_bridge_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import axi_proto_pkg::*;
  import mem_fifo_pkg::*;

  localparam int N_TXN = 12;

  // kind 0 write, 1 read, 2 write and read presented together, 3 two reads back to back
  typedef struct packed {
    logic [1:0]  kind;
    logic [3:0]  id;
    logic [31:0] addr;
    axi_len_t    len;
    axi_burst_e  burst;
    axi_size_t   size;
    logic [31:0] seed;
    logic [7:0]  strb;
    logic [7:0]  hold;
  } txn_t;

  txn_t txn_table [N_TXN];

  logic clk, reset;
  logic [3:0] awid, arid, bid, rid;
  logic [31:0] awaddr, araddr, mem_addr;
  axi_len_t awlen, arlen;
  axi_size_t awsize, arsize, mem_size;
  axi_burst_e awburst, arburst;
  logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic arvalid, arready, rvalid, rready, rlast;
  logic [63:0] wdata, rdata, mem_data, mem_rsp_data;
  logic [7:0] wstrb, mem_wmask;
  axi_resp_e bresp, rresp;
  logic mem_v, mem_ready, mem_rsp_v, mem_rsp_ready;
  mem_cmd_e mem_cmd, mem_rsp_cmd;

  logic [63:0] ref_mem [256];
  mem_cmd_e    exp_cmd_q [$];
  logic [31:0] exp_addr_q [$];
  axi_size_t   exp_size_q [$];
  int error_count;
  int b_count;
  int exp_b_count;

  tb_clock_gen clock_gen (.clk_o(clk), .reset_o(reset));

  axi_fifo_bridge uut (
    .clk_i(clk), .reset_i(reset)
    , .s_axi_awid_i(awid), .s_axi_awaddr_i(awaddr), .s_axi_awlen_i(awlen)
    , .s_axi_awsize_i(awsize), .s_axi_awburst_i(awburst)
    , .s_axi_awvalid_i(awvalid), .s_axi_awready_o(awready)
    , .s_axi_wdata_i(wdata), .s_axi_wstrb_i(wstrb), .s_axi_wlast_i(wlast)
    , .s_axi_wvalid_i(wvalid), .s_axi_wready_o(wready)
    , .s_axi_bid_o(bid), .s_axi_bresp_o(bresp), .s_axi_bvalid_o(bvalid)
    , .s_axi_bready_i(bready)
    , .s_axi_arid_i(arid), .s_axi_araddr_i(araddr), .s_axi_arlen_i(arlen)
    , .s_axi_arsize_i(arsize), .s_axi_arburst_i(arburst)
    , .s_axi_arvalid_i(arvalid), .s_axi_arready_o(arready)
    , .s_axi_rid_o(rid), .s_axi_rdata_o(rdata), .s_axi_rresp_o(rresp)
    , .s_axi_rlast_o(rlast), .s_axi_rvalid_o(rvalid), .s_axi_rready_i(rready)
    , .mem_v_o(mem_v), .mem_cmd_o(mem_cmd), .mem_addr_o(mem_addr)
    , .mem_size_o(mem_size), .mem_wmask_o(mem_wmask), .mem_data_o(mem_data)
    , .mem_ready_i(mem_ready)
    , .mem_rsp_v_i(mem_rsp_v), .mem_rsp_cmd_i(mem_rsp_cmd)
    , .mem_rsp_data_i(mem_rsp_data), .mem_rsp_ready_o(mem_rsp_ready)
  );

  mem_responder responder (
    .clk_i(clk), .reset_i(reset)
    , .mem_v_i(mem_v), .mem_cmd_i(mem_cmd), .mem_addr_i(mem_addr)
    , .mem_wmask_i(mem_wmask), .mem_data_i(mem_data), .mem_ready_o(mem_ready)
    , .mem_rsp_v_o(mem_rsp_v), .mem_rsp_cmd_o(mem_rsp_cmd)
    , .mem_rsp_data_o(mem_rsp_data), .mem_rsp_ready_i(mem_rsp_ready)
  );

  function automatic logic [63:0] fill_word(input logic [7:0] idx);
    return {32'hc3a5_0000 | {24'h0, idx}, 32'h1234_5678 ^ {idx, idx, idx, idx}};
  endfunction

  function automatic logic [63:0] beat_data(input logic [31:0] seed, input int beat);
    return {seed + beat, ~seed ^ (beat * 32'h0101_0101)};
  endfunction

  function automatic logic [31:0] beat_addr(input txn_t t, input int beat);
    if (t.burst == e_burst_fixed) begin
      return t.addr;
    end
    return t.addr + beat * (1 << t.size);
  endfunction

  // same burst shape, starting right after the given burst ends
  function automatic txn_t following_burst(input txn_t t);
    txn_t n;
    n = t;
    n.addr = t.addr + ((t.len + 32'd1) << t.size);
    return n;
  endfunction

  task automatic check_bresp(input logic [3:0] got_id, input axi_resp_e got_resp,
                             input logic [3:0] exp_id);
    if (got_id !== exp_id || got_resp !== e_resp_okay) begin
      error_count++;
      $display("ERROR %0t: B id %0h resp %0d, expected id %0h OKAY",
               $time, got_id, got_resp, exp_id);
    end
  endtask

  task automatic check_rbeat(input logic [3:0] got_id, input logic [63:0] got_data,
                             input axi_resp_e got_resp, input logic got_last,
                             input logic [3:0] exp_id, input logic [63:0] exp_data,
                             input logic exp_last);
    if (got_id !== exp_id || got_data !== exp_data || got_resp !== e_resp_okay ||
        got_last !== exp_last) begin
      error_count++;
      $display("ERROR %0t: R id %0h data %h resp %0d last %b, expected id %0h data %h last %b",
               $time, got_id, got_data, got_resp, got_last, exp_id, exp_data, exp_last);
    end
  endtask

  task automatic check_mem_req(input mem_cmd_e got_cmd, input logic [31:0] got_addr,
                               input axi_size_t got_size, input mem_cmd_e exp_cmd,
                               input logic [31:0] exp_addr, input axi_size_t exp_size);
    if (got_cmd !== exp_cmd || got_addr !== exp_addr || got_size !== exp_size) begin
      error_count++;
      $display("ERROR %0t: request %s @%h size %0d, expected %s @%h size %0d",
               $time, got_cmd.name(), got_addr, got_size, exp_cmd.name(), exp_addr,
               exp_size);
    end
  endtask

  task automatic expect_reqs(input txn_t t, input mem_cmd_e cmd);
    for (int b = 0; b <= t.len; b++) begin
      exp_cmd_q.push_back(cmd);
      exp_addr_q.push_back(beat_addr(t, b));
      exp_size_q.push_back(t.size);
    end
  endtask

  task automatic write_txn(input txn_t t, input logic [3:0] id);
    logic [7:0] idx;
    logic [63:0] d;
    if (t.hold != 0) begin
      bready <= 1'b0;
    end
    // W beats go in alongside AW so both are waiting when the FSM looks
    fork
      begin
        awid <= id;
        awaddr <= t.addr;
        awlen <= t.len;
        awsize <= t.size;
        awburst <= t.burst;
        awvalid <= 1'b1;
        do @(posedge clk); while (!awready);
        awvalid <= 1'b0;
      end
      begin
        for (int b = 0; b <= t.len; b++) begin
          wdata <= beat_data(t.seed, b);
          wstrb <= t.strb;
          wlast <= (b == t.len);
          wvalid <= 1'b1;
          do @(posedge clk); while (!wready);
        end
        wvalid <= 1'b0;
      end
    join
    repeat (t.hold) @(posedge clk);
    bready <= 1'b1;
    do @(posedge clk); while (!(bvalid && bready));
    check_bresp(bid, bresp, id);
    for (int b = 0; b <= t.len; b++) begin
      idx = beat_addr(t, b) >> 3;
      d = beat_data(t.seed, b);
      for (int k = 0; k < 8; k++) begin
        if (t.strb[k]) begin
          ref_mem[idx][k*8 +: 8] = d[k*8 +: 8];
        end
      end
    end
  endtask

  task automatic send_ar(input txn_t t, input logic [3:0] id);
    arid <= id;
    araddr <= t.addr;
    arlen <= t.len;
    arsize <= t.size;
    arburst <= t.burst;
    arvalid <= 1'b1;
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
  endtask

  task automatic collect_r(input txn_t t, input logic [3:0] id);
    for (int b = 0; b <= t.len; b++) begin
      do @(posedge clk); while (!(rvalid && rready));
      check_rbeat(rid, rdata, rresp, rlast, id, ref_mem[beat_addr(t, b) >> 3], b == t.len);
    end
  endtask

  task automatic read_txn(input txn_t t, input logic [3:0] id);
    logic [63:0] exp_data [$];
    for (int b = 0; b <= t.len; b++) begin
      exp_data.push_back(ref_mem[beat_addr(t, b) >> 3]);
    end
    if (t.hold != 0) begin
      rready <= 1'b0;
    end
    send_ar(t, id);
    repeat (t.hold) @(posedge clk);
    rready <= 1'b1;
    for (int b = 0; b <= t.len; b++) begin
      do @(posedge clk); while (!(rvalid && rready));
      check_rbeat(rid, rdata, rresp, rlast, id, exp_data[b], b == t.len);
    end
  endtask

  // the second AR is queued while the first burst is still in flight
  task automatic read_pair(input txn_t t, input logic [3:0] id);
    txn_t t2;
    t2 = following_burst(t);
    fork
      begin
        send_ar(t, id);
        send_ar(t2, id + 4'h1);
      end
      begin
        collect_r(t, id);
        collect_r(t2, id + 4'h1);
      end
    join
  endtask

  // every accepted memory request must match the next expected one
  always @(posedge clk) begin
    if (!reset && mem_v && mem_ready) begin
      if (exp_cmd_q.size() == 0) begin
        error_count++;
        $display("ERROR %0t: memory request @%h that no transaction asked for",
                 $time, mem_addr);
      end else begin
        check_mem_req(mem_cmd, mem_addr, mem_size,
                      exp_cmd_q.pop_front(), exp_addr_q.pop_front(), exp_size_q.pop_front());
      end
    end
    if (!reset && bvalid && bready) begin
      b_count++;
    end
  end

  initial begin
    #(N_TXN * 64 * 10);
    $display("timeout: the transactions did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    txn_table[0]  = '{2'd0, 4'h1, 32'h040, 8'd0, e_burst_incr,  3'd3, 32'h1111_0001, 8'h0f, 8'd0};
    txn_table[1]  = '{2'd1, 4'h2, 32'h040, 8'd0, e_burst_incr,  3'd3, 32'h0, 8'h00, 8'd0};
    txn_table[2]  = '{2'd0, 4'h3, 32'h100, 8'd7, e_burst_incr,  3'd3, 32'h2222_0002, 8'hff, 8'd0};
    txn_table[3]  = '{2'd1, 4'h4, 32'h100, 8'd7, e_burst_incr,  3'd3, 32'h0, 8'h00, 8'd0};
    txn_table[4]  = '{2'd1, 4'h5, 32'h108, 8'd3, e_burst_fixed, 3'd3, 32'h0, 8'h00, 8'd0};
    txn_table[5]  = '{2'd2, 4'h6, 32'h200, 8'd1, e_burst_incr,  3'd3, 32'h3333_0003, 8'hff, 8'd0};
    txn_table[6]  = '{2'd1, 4'h8, 32'h100, 8'd3, e_burst_incr,  3'd3, 32'h0, 8'h00, 8'd20};
    txn_table[7]  = '{2'd0, 4'h9, 32'h300, 8'd2, e_burst_incr,  3'd3, 32'h4444_0004, 8'hf0, 8'd20};
    txn_table[8]  = '{2'd0, 4'ha, 32'h310, 8'd0, e_burst_incr,  3'd3, 32'h5555_0005, 8'hff, 8'd0};
    txn_table[9]  = '{2'd3, 4'hb, 32'h300, 8'd3, e_burst_incr,  3'd3, 32'h0, 8'h00, 8'd0};
    txn_table[10] = '{2'd0, 4'hc, 32'h7f8, 8'd0, e_burst_incr,  3'd3, 32'h6666_0006, 8'h3c, 8'd0};
    txn_table[11] = '{2'd1, 4'hd, 32'h7f8, 8'd0, e_burst_incr,  3'd3, 32'h0, 8'h00, 8'd0};
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = fill_word(i[7:0]);
    end
    error_count = 0;
    b_count = 0;
    exp_b_count = 0;
    awid = '0;
    awaddr = '0;
    awlen = '0;
    awsize = '0;
    awburst = e_burst_incr;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wlast = 1'b0;
    wvalid = 1'b0;
    bready = 1'b1;
    arid = '0;
    araddr = '0;
    arlen = '0;
    arsize = '0;
    arburst = e_burst_incr;
    arvalid = 1'b0;
    rready = 1'b1;
    @(posedge clk);
    while (reset) @(posedge clk);
    for (int i = 0; i < N_TXN; i++) begin
      case (txn_table[i].kind)
        2'd0: begin
          expect_reqs(txn_table[i], e_mem_write);
          exp_b_count++;
          write_txn(txn_table[i], txn_table[i].id);
        end
        2'd1: begin
          expect_reqs(txn_table[i], e_mem_read);
          read_txn(txn_table[i], txn_table[i].id);
        end
        2'd2: begin
          // the read goes to memory first
          expect_reqs(txn_table[i], e_mem_read);
          expect_reqs(txn_table[i], e_mem_write);
          exp_b_count++;
          fork
            write_txn(txn_table[i], txn_table[i].id);
            read_txn(txn_table[i], txn_table[i].id + 4'h1);
          join
        end
        default: begin
          // the second read waits behind the first in the ID FIFO
          expect_reqs(txn_table[i], e_mem_read);
          expect_reqs(following_burst(txn_table[i]), e_mem_read);
          read_pair(txn_table[i], txn_table[i].id);
        end
      endcase
    end
    repeat (10) @(posedge clk);
    if (exp_cmd_q.size() != 0) begin
      error_count++;
      $display("ERROR %0t: %0d expected memory requests never issued",
               $time, exp_cmd_q.size());
    end
    if (b_count != exp_b_count) begin
      error_count++;
      $display("ERROR %0t: %0d B responses, expected %0d", $time, b_count, exp_b_count);
    end
    $display("test finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/mem_responder.sv ====
`default_nettype none

`include "axi_fifo_bridge_config.svh"

module mem_responder (
  input  logic                      clk_i
  , input  logic                      reset_i
  , input  logic                      mem_v_i
  , input  mem_fifo_pkg::mem_cmd_e    mem_cmd_i
  , input  logic [`BRIDGE_ADDR_W-1:0] mem_addr_i
  , input  logic [`BRIDGE_MASK_W-1:0] mem_wmask_i
  , input  logic [`BRIDGE_DATA_W-1:0] mem_data_i
  , output logic                      mem_ready_o
  , output logic                      mem_rsp_v_o
  , output mem_fifo_pkg::mem_cmd_e    mem_rsp_cmd_o
  , output logic [`BRIDGE_DATA_W-1:0] mem_rsp_data_o
  , input  logic                      mem_rsp_ready_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import mem_fifo_pkg::*;

  logic [`BRIDGE_DATA_W-1:0] mem [256];
  mem_rsp_t                  pending_q [$];
  int unsigned               delay_cnt;

  // each word carries its own index in both halves
  function automatic logic [63:0] fill_word(input logic [7:0] idx);
    return {32'hc3a5_0000 | {24'h0, idx}, 32'h1234_5678 ^ {idx, idx, idx, idx}};
  endfunction

  initial begin
    void'($urandom(32'ha005_5874));
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(i[7:0]);
    end
    mem_ready_o    = 1'b0;
    mem_rsp_v_o    = 1'b0;
    mem_rsp_cmd_o  = e_mem_read;
    mem_rsp_data_o = '0;
    delay_cnt      = 0;
  end

  always @(posedge clk_i) begin
    mem_rsp_t rsp;
    logic [7:0] idx;
    if (reset_i) begin
      mem_ready_o <= 1'b0;
      mem_rsp_v_o <= 1'b0;
    end else begin
      // present the next response once the current one is taken
      if (!(mem_rsp_v_o && !mem_rsp_ready_i)) begin
        if (pending_q.size() > 0 && delay_cnt == 0) begin
          rsp = pending_q.pop_front();
          mem_rsp_v_o    <= 1'b1;
          mem_rsp_cmd_o  <= rsp.cmd;
          mem_rsp_data_o <= rsp.data;
          delay_cnt = $urandom % 4;
        end else begin
          mem_rsp_v_o <= 1'b0;
          if (delay_cnt > 0) begin
            delay_cnt--;
          end
        end
      end
      if (mem_v_i && mem_ready_o) begin
        idx = mem_addr_i[10:3];
        if (mem_cmd_i == e_mem_write) begin
          for (int b = 0; b < `BRIDGE_MASK_W; b++) begin
            if (mem_wmask_i[b]) begin
              mem[idx][b*8 +: 8] = mem_data_i[b*8 +: 8];
            end
          end
        end
        rsp.cmd  = mem_cmd_i;
        rsp.data = mem[idx];
        pending_q.push_back(rsp);
      end
      // stalls about one cycle in four
      mem_ready_o <= (($urandom % 4) != 0);
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic clk_o
  , output logic reset_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset held for four rising edges
  initial begin
    reset_o = 1'b1;
    repeat (4) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire
